// File: Bender.yml
package:
  name: neuro_board_core

sources:
  - hw/neuro_pkg.sv
  - hw/param_bank.sv
  - hw/mn_neuron.sv
  - hw/spike_window_counter.sv
  - hw/emg_combiner.sv
  - hw/neuro_board_core.sv
  - target: simulation
    files:
      - verification/neuro_board_chk.sv
      - verification/tb_neuro_board.sv

// File: hw/emg_combiner.sv
`timescale 1ns/1ps

module emg_combiner #(
    parameter neuro_pkg::spike_cnt_t CNT_SAT = 16'hFFFF
) (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     i_done,
    input  neuro_pkg::spike_cnt_t    i_local_cnt,
    input  neuro_pkg::spike_cnt_t    i_remote_cnt,
    input  neuro_pkg::neuro_params_t i_params,
    output neuro_pkg::spike_cnt_t    o_combined,
    output neuro_pkg::emg_t          o_emg,
    output logic                     o_emg_valid
);

    // emg_t range, widened to the working width
    localparam logic signed [19:0] EMG_MAX = 20'sd131071;
    localparam logic signed [19:0] EMG_MIN = -20'sd131072;

    logic [16:0]           cnt_sum;
    neuro_pkg::spike_cnt_t combined_next;
    logic signed [19:0]    emg_ext;
    logic signed [19:0]    leak_term;
    logic signed [19:0]    cnt_ext;
    logic signed [19:0]    emg_sum;
    neuro_pkg::emg_t       emg_next;
    neuro_pkg::spike_cnt_t combined_q;
    neuro_pkg::emg_t       emg_q;
    logic                  valid_q;

    //////////////////////////////
    // short plus long latency
    //////////////////////////////

    assign cnt_sum       = {1'b0, i_local_cnt} + {1'b0, i_remote_cnt};
    assign combined_next = (cnt_sum > {1'b0, CNT_SAT}) ? CNT_SAT : cnt_sum[15:0];

    //////////////////////////////
    // leaky integrator
    //////////////////////////////

    // emg - (emg >>> leak) + combined, two guard bits
    assign emg_ext   = {{2{emg_q[17]}}, emg_q};
    assign leak_term = emg_ext >>> i_params.leak_shift;
    assign cnt_ext   = {4'b0000, combined_next};
    assign emg_sum   = emg_ext - leak_term + cnt_ext;

    // clamp at both ends of emg_t
    always_comb
    begin
        if (emg_sum > EMG_MAX)
            emg_next = EMG_MAX[17:0];
        else if (emg_sum < EMG_MIN)
            emg_next = EMG_MIN[17:0];
        else
            emg_next = emg_sum[17:0];
    end

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            combined_q <= '0;
            emg_q      <= '0;
            valid_q    <= 1'b0;
        end
        else
        begin
            // one update per finished window
            valid_q <= i_done;
            if (i_done)
            begin
                combined_q <= combined_next;
                emg_q      <= emg_next;
            end
        end
    end

    assign o_combined  = combined_q;
    assign o_emg       = emg_q;
    assign o_emg_valid = valid_q;

endmodule

// File: hw/mn_neuron.sv
`timescale 1ns/1ps

module mn_neuron (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     i_run,
    input  neuro_pkg::neuro_params_t i_params,
    output logic                     o_spike
);

    // membrane accumulator, one bit above the parameter word
    logic [32:0] acc_q;
    // accumulator plus drive, with carry room
    logic [33:0] acc_sum;
    // what is left after a firing
    logic [32:0] acc_rem;
    logic        fire;
    logic        spike_q;

    //////////////////////////////
    // integrate and compare
    //////////////////////////////

    assign acc_sum = {1'b0, acc_q} + {2'b00, i_params.drive};

    // threshold 0 means never fire
    assign fire = (i_params.threshold != '0) &&
                  (acc_sum >= {2'b00, i_params.threshold});

    // modulo 2^33, same as the full difference in the low bits
    assign acc_rem = acc_sum[32:0] - {1'b0, i_params.threshold};

    //////////////////////////////
    // state update
    //////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            acc_q   <= '0;
            spike_q <= 1'b0;
        end
        else if (i_run)
        begin
            // pulse lands one cycle after the crossing
            spike_q <= fire;
            if (fire)
            begin
                acc_q <= acc_rem;
            end
            else
            begin
                acc_q <= acc_sum[32:0];
            end
        end
        else
        begin
            // stopped, accumulator frozen
            spike_q <= 1'b0;
        end
    end

    assign o_spike = spike_q;

endmodule

// File: hw/neuro_board_core.sv
`timescale 1ns/1ps

module neuro_board_core #(
    parameter neuro_pkg::spike_cnt_t CNT_SAT = 16'hFFFF
) (
    input  logic                  ep50trig,
    input  logic                  reset_global,
    input  logic                  i_run,
    input  logic                  i_load,
    input  neuro_pkg::param_sel_t i_sel,
    input  logic [15:0]           i_data_hi,
    input  logic [15:0]           i_data_lo,
    // cross-board spikes, already on ep50trig
    input  logic                  i_spike_in,
    output logic                  o_mn_spike,
    output neuro_pkg::spike_cnt_t o_local_cnt,
    output neuro_pkg::spike_cnt_t o_remote_cnt,
    output logic                  o_cnt_done,
    output neuro_pkg::spike_cnt_t o_combined,
    output neuro_pkg::emg_t       o_emg,
    output logic                  o_emg_valid
);

    neuro_pkg::neuro_params_t params;
    logic                     mn_spike;
    logic                     local_done;
    // lines up with local_done, both timers share params and reset
    logic                     remote_done;

    //////////////////////////////
    // host parameters
    //////////////////////////////

    param_bank bank (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_load       (i_load),
        .i_sel        (i_sel),
        .i_data_hi    (i_data_hi),
        .i_data_lo    (i_data_lo),
        .o_params     (params)
    );

    // local motor neuron
    mn_neuron motor_neuron (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_run        (i_run),
        .i_params     (params),
        .o_spike      (mn_spike)
    );

    //////////////////////////////
    // window counters
    //////////////////////////////

    // short latency loop
    spike_window_counter #(.CNT_SAT(CNT_SAT)) local_counter (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_spike      (mn_spike),
        .i_params     (params),
        .o_count      (o_local_cnt),
        .o_done       (local_done)
    );

    // long latency loop from the second board
    spike_window_counter #(.CNT_SAT(CNT_SAT)) remote_counter (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_spike      (i_spike_in),
        .i_params     (params),
        .o_count      (o_remote_cnt),
        .o_done       (remote_done)
    );

    // sum and emg, paced by the local window
    emg_combiner #(.CNT_SAT(CNT_SAT)) combiner (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_done       (local_done),
        .i_local_cnt  (o_local_cnt),
        .i_remote_cnt (o_remote_cnt),
        .i_params     (params),
        .o_combined   (o_combined),
        .o_emg        (o_emg),
        .o_emg_valid  (o_emg_valid)
    );

    assign o_mn_spike = mn_spike;
    assign o_cnt_done = local_done;

endmodule

// File: hw/neuro_pkg.sv
package neuro_pkg;

    //////////////////////////////
    // vector types
    //////////////////////////////

    // one host parameter value, {data_hi, data_lo}
    typedef logic [31:0] param_word_t;

    // spike total of one window, unsigned
    typedef logic [15:0] spike_cnt_t;

    // window length in ep50trig cycles
    typedef logic [17:0] window_t;

    // emg estimate, two's complement
    typedef logic signed [17:0] emg_t;

    //////////////////////////////
    // host parameter select
    //////////////////////////////

    // trigger select codes, anything else is dropped
    typedef enum logic [3:0] {
        SEL_WINDOW     = 4'd0,
        SEL_DRIVE      = 4'd1,
        SEL_THRESHOLD  = 4'd2,
        SEL_LEAK_SHIFT = 4'd3
    } param_sel_t;

    // full model parameter set, fans out from the bank
    typedef struct packed {
        window_t     window_len;
        param_word_t drive;
        param_word_t threshold;
        logic [3:0]  leak_shift;
    } neuro_params_t;

    // power-up values of the bank
    localparam window_t     DEF_WINDOW_LEN = 18'd100;
    localparam param_word_t DEF_DRIVE      = 32'd0;
    localparam param_word_t DEF_THRESHOLD  = 32'd1000;
    localparam logic [3:0]  DEF_LEAK_SHIFT = 4'd3;

endpackage

// File: hw/param_bank.sv
`timescale 1ns/1ps

module param_bank (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     i_load,
    input  neuro_pkg::param_sel_t    i_sel,
    input  logic [15:0]              i_data_hi,
    input  logic [15:0]              i_data_lo,
    output neuro_pkg::neuro_params_t o_params
);

    // host word as the two endpoint halves
    neuro_pkg::param_word_t   load_word;
    neuro_pkg::neuro_params_t params_q;

    assign load_word = {i_data_hi, i_data_lo};

    //////////////////////////////
    // trigger-loaded registers
    //////////////////////////////

    // one field per strobe, selected by the enum
    // narrower fields keep the low bits of the word
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            params_q.window_len <= neuro_pkg::DEF_WINDOW_LEN;
            params_q.drive      <= neuro_pkg::DEF_DRIVE;
            params_q.threshold  <= neuro_pkg::DEF_THRESHOLD;
            params_q.leak_shift <= neuro_pkg::DEF_LEAK_SHIFT;
        end
        else if (i_load)
        begin
            case (i_sel)
                neuro_pkg::SEL_WINDOW:
                begin
                    params_q.window_len <= load_word[$bits(neuro_pkg::window_t)-1:0];
                end
                neuro_pkg::SEL_DRIVE:
                begin
                    params_q.drive <= load_word;
                end
                neuro_pkg::SEL_THRESHOLD:
                begin
                    params_q.threshold <= load_word;
                end
                neuro_pkg::SEL_LEAK_SHIFT:
                begin
                    params_q.leak_shift <= load_word[3:0];
                end
                default:
                begin
                    // unknown code, bank unchanged
                    params_q <= params_q;
                end
            endcase
        end
    end

    // registered, new value seen one cycle after the load edge
    assign o_params = params_q;

endmodule

// File: hw/spike_window_counter.sv
`timescale 1ns/1ps

module spike_window_counter #(
    parameter neuro_pkg::spike_cnt_t CNT_SAT = 16'hFFFF
) (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     i_spike,
    input  neuro_pkg::neuro_params_t i_params,
    output neuro_pkg::spike_cnt_t    o_count,
    output logic                     o_done
);

    // window length with the floor of 2 applied
    neuro_pkg::window_t    eff_len;
    // cycle index inside the running window
    neuro_pkg::window_t    tmr_q;
    // last index, latched at each window start
    neuro_pkg::window_t    last_q;
    logic                  win_end;
    neuro_pkg::spike_cnt_t acc_q;
    neuro_pkg::spike_cnt_t acc_inc;
    neuro_pkg::spike_cnt_t count_q;
    logic                  done_q;

    assign eff_len = (i_params.window_len < 18'd2) ? 18'd2 : i_params.window_len;
    assign win_end = (tmr_q == last_q);

    // saturating increment
    assign acc_inc = (i_spike && (acc_q < CNT_SAT)) ? acc_q + 16'd1 : acc_q;

    //////////////////////////////
    // window timer and counter
    //////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            tmr_q   <= '0;
            last_q  <= neuro_pkg::DEF_WINDOW_LEN - 18'd1;
            acc_q   <= '0;
            count_q <= '0;
            done_q  <= 1'b0;
        end
        else if (win_end)
        begin
            // publish the total, restart with the current length
            tmr_q   <= '0;
            last_q  <= eff_len - 18'd1;
            acc_q   <= '0;
            count_q <= acc_inc;
            done_q  <= 1'b1;
        end
        else
        begin
            tmr_q  <= tmr_q + 18'd1;
            acc_q  <= acc_inc;
            done_q <= 1'b0;
        end
    end

    // count held until the next done
    assign o_count = count_q;
    assign o_done  = done_q;

endmodule

// File: verification/neuro_board_chk.sv
`timescale 1ns/1ps

module neuro_board_chk (
    input logic ep50trig,
    input logic reset_global,
    input logic o_mn_spike,
    input logic o_cnt_done,
    input logic o_emg_valid,
    input logic local_done,
    input logic remote_done
);

    // tally of failed assertions
    int unsigned fail_count = 0;

    //////////////////////////////
    // strobe widths
    //////////////////////////////

    done_one_cycle: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_cnt_done |=> !o_cnt_done)
    else
    begin
        $error("count done stayed high for more than one cycle");
        fail_count++;
    end

    valid_one_cycle: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_emg_valid |=> !o_emg_valid)
    else
    begin
        $error("emg valid stayed high for more than one cycle");
        fail_count++;
    end

    //////////////////////////////
    // pipeline timing
    //////////////////////////////

    // emg update one cycle behind the window end
    valid_after_done: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_cnt_done |=> o_emg_valid)
    else
    begin
        $error("emg valid missing one cycle after count done");
        fail_count++;
    end

    valid_only_after_done: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        o_emg_valid |-> $past(o_cnt_done))
    else
    begin
        $error("emg valid without a count done the cycle before");
        fail_count++;
    end

    // local and remote windows in lock step
    counters_aligned: assert property (
        @(posedge ep50trig) disable iff (reset_global)
        local_done == remote_done)
    else
    begin
        $error("local and remote window ends differ");
        fail_count++;
    end

    // quiet outputs once reset has been seen
    quiet_in_reset: assert property (
        @(posedge ep50trig)
        (reset_global && $past(reset_global)) |-> (!o_mn_spike && !o_cnt_done && !o_emg_valid))
    else
    begin
        $error("strobe high during reset");
        fail_count++;
    end

endmodule

bind neuro_board_core neuro_board_chk chk (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .o_mn_spike   (o_mn_spike),
    .o_cnt_done   (o_cnt_done),
    .o_emg_valid  (o_emg_valid),
    .local_done   (local_done),
    .remote_done  (remote_done)
);

// File: verification/tb_neuro_board.sv
`timescale 1ns/1ps

module tb_neuro_board;

    localparam int CLK_HALF        = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int DEFAULT_CYCLES  = 120;
    localparam int ROUNDS          = 8;
    localparam int RANDOM_LOADS    = 5;
    // random loads plus the unknown-select and leak loads
    localparam int LOADS_PER_ROUND = RANDOM_LOADS + 2;
    localparam int ROUND_CYCLES    = 300;
    localparam int SAT_LOADS       = 3;
    localparam int SAT_CYCLES      = 500;
    localparam int MARGIN          = 200;
    localparam int MAX_CYCLES      = RESET_CYCLES + DEFAULT_CYCLES
                                     + ROUNDS * (LOADS_PER_ROUND + ROUND_CYCLES)
                                     + SAT_LOADS + SAT_CYCLES + MARGIN;
    // short count limit so dense windows clip
    localparam neuro_pkg::spike_cnt_t SAT_LIMIT = 16'd60;
    // emg_t range, 18 bit two's complement
    localparam int     EMG_HI   = (1 << 17) - 1;
    localparam int     EMG_LO   = -(1 << 17);
    // 33 bit membrane accumulator
    localparam longint ACC_MASK = (longint'(1) << 33) - 1;

    logic                  ep50trig;
    logic                  reset_global;
    logic                  i_run;
    logic                  i_load;
    neuro_pkg::param_sel_t i_sel;
    logic [15:0]           i_data_hi;
    logic [15:0]           i_data_lo;
    logic                  i_spike_in;
    logic                  o_mn_spike;
    neuro_pkg::spike_cnt_t o_local_cnt;
    neuro_pkg::spike_cnt_t o_remote_cnt;
    logic                  o_cnt_done;
    neuro_pkg::spike_cnt_t o_combined;
    neuro_pkg::emg_t       o_emg;
    logic                  o_emg_valid;

    logic [31:0] lfsr_state;
    int unsigned cycle_count;
    int unsigned check_count;
    int unsigned error_count;

    //////////////////////////////
    // reference model state
    //////////////////////////////

    neuro_pkg::neuro_params_t m_par;
    longint                   m_acc;
    logic                     m_spike;
    // cycles left in the running window, this one included
    int                       m_left;
    neuro_pkg::spike_cnt_t    m_lacc;
    neuro_pkg::spike_cnt_t    m_racc;
    neuro_pkg::spike_cnt_t    m_lcnt;
    neuro_pkg::spike_cnt_t    m_rcnt;
    logic                     m_done;
    neuro_pkg::spike_cnt_t    m_comb;
    int                       m_emg;
    logic                     m_valid;

    neuro_board_core #(.CNT_SAT(SAT_LIMIT)) UUT (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_run        (i_run),
        .i_load       (i_load),
        .i_sel        (i_sel),
        .i_data_hi    (i_data_hi),
        .i_data_lo    (i_data_lo),
        .i_spike_in   (i_spike_in),
        .o_mn_spike   (o_mn_spike),
        .o_local_cnt  (o_local_cnt),
        .o_remote_cnt (o_remote_cnt),
        .o_cnt_done   (o_cnt_done),
        .o_combined   (o_combined),
        .o_emg        (o_emg),
        .o_emg_valid  (o_emg_valid)
    );

    // 40 ns period
    initial
    begin
        ep50trig = 1'b0;
        forever #CLK_HALF ep50trig = ~ep50trig;
    end

    //////////////////////////////
    // random source
    //////////////////////////////

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // one lfsr step per bit taken
    function logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // count of one window, clipped at the limit
    function automatic neuro_pkg::spike_cnt_t count_up(input neuro_pkg::spike_cnt_t c,
                                                       input logic hit);
        if (hit && (c < SAT_LIMIT))
            return c + 16'd1;
        return c;
    endfunction

    //////////////////////////////
    // cycle model
    //////////////////////////////

    // stages in reverse order so each reads last cycle's values
    task automatic model_step();
        int                    sum_cnt;
        int                    emg_new;
        longint                acc_sum;
        logic                  fire;
        logic [31:0]           load_word;
        neuro_pkg::spike_cnt_t l_next;
        neuro_pkg::spike_cnt_t r_next;
        if (reset_global)
        begin
            m_par.window_len = neuro_pkg::DEF_WINDOW_LEN;
            m_par.drive      = neuro_pkg::DEF_DRIVE;
            m_par.threshold  = neuro_pkg::DEF_THRESHOLD;
            m_par.leak_shift = neuro_pkg::DEF_LEAK_SHIFT;
            m_acc   = 0;
            m_spike = 1'b0;
            m_left  = int'(neuro_pkg::DEF_WINDOW_LEN);
            m_lacc  = '0;
            m_racc  = '0;
            m_lcnt  = '0;
            m_rcnt  = '0;
            m_done  = 1'b0;
            m_comb  = '0;
            m_emg   = 0;
            m_valid = 1'b0;
        end
        else
        begin
            // combiner, fed by last cycle's counts
            m_valid = m_done;
            if (m_done)
            begin
                sum_cnt = int'(m_lcnt) + int'(m_rcnt);
                if (sum_cnt > int'(SAT_LIMIT))
                    m_comb = SAT_LIMIT;
                else
                    m_comb = neuro_pkg::spike_cnt_t'(sum_cnt);
                emg_new = m_emg - (m_emg >>> m_par.leak_shift) + int'(m_comb);
                if (emg_new > EMG_HI)
                    emg_new = EMG_HI;
                else if (emg_new < EMG_LO)
                    emg_new = EMG_LO;
                m_emg = emg_new;
            end

            // both windows, local one sees the registered spike
            l_next = count_up(m_lacc, m_spike);
            r_next = count_up(m_racc, i_spike_in);
            if (m_left == 1)
            begin
                m_lcnt = l_next;
                m_rcnt = r_next;
                m_lacc = '0;
                m_racc = '0;
                m_left = (m_par.window_len < 2) ? 2 : int'(m_par.window_len);
                m_done = 1'b1;
            end
            else
            begin
                m_lacc = l_next;
                m_racc = r_next;
                m_left = m_left - 1;
                m_done = 1'b0;
            end

            // integrate and fire
            if (i_run)
            begin
                acc_sum = m_acc + longint'(m_par.drive);
                fire    = (m_par.threshold != 0) && (acc_sum >= longint'(m_par.threshold));
                if (fire)
                    acc_sum = acc_sum - longint'(m_par.threshold);
                m_acc   = acc_sum & ACC_MASK;
                m_spike = fire;
            end
            else
            begin
                m_spike = 1'b0;
            end

            // parameter bank last, seen by the others next cycle
            if (i_load)
            begin
                load_word = {i_data_hi, i_data_lo};
                case (i_sel)
                    neuro_pkg::SEL_WINDOW:     m_par.window_len = neuro_pkg::window_t'(load_word);
                    neuro_pkg::SEL_DRIVE:      m_par.drive      = load_word;
                    neuro_pkg::SEL_THRESHOLD:  m_par.threshold  = load_word;
                    neuro_pkg::SEL_LEAK_SHIFT: m_par.leak_shift = load_word[3:0];
                    default: ;
                endcase
            end
        end
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("Mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // every output against the model
    task automatic check_outputs();
        compare(o_mn_spike, m_spike, "o_mn_spike");
        compare(o_local_cnt, m_lcnt, "o_local_cnt");
        compare(o_remote_cnt, m_rcnt, "o_remote_cnt");
        compare(o_cnt_done, m_done, "o_cnt_done");
        compare(o_combined, m_comb, "o_combined");
        compare(o_emg, m_emg, "o_emg");
        compare(o_emg_valid, m_valid, "o_emg_valid");
    endtask

    // outputs settled at the falling edge, new inputs go on after
    task automatic tick();
        @(negedge ep50trig);
        model_step();
        check_outputs();
    endtask

    //////////////////////////////
    // host strobes
    //////////////////////////////

    task automatic host_load(input logic [3:0] sel, input logic [15:0] hi, input logic [15:0] lo);
        i_load    = 1'b1;
        i_sel     = neuro_pkg::param_sel_t'(sel);
        i_data_hi = hi;
        i_data_lo = lo;
        tick();
        i_load    = 1'b0;
    endtask

    // one of the four known fields, with random upper bits
    task automatic random_load();
        logic [1:0]  code;
        logic [15:0] hi;
        logic [15:0] lo;
        code = 2'(random_bits(2));
        hi   = 16'(random_bits(16));
        lo   = 16'(random_bits(16));
        case (code)
            2'd0:
            begin
                // window 0 to 255, bits above 17 dropped
                hi[1:0]  = 2'b00;
                lo[15:8] = 8'h00;
            end
            2'd1:
            begin
                hi        = '0;
                lo[15:12] = 4'h0;
            end
            2'd2:
            begin
                hi        = '0;
                lo[15:14] = 2'b00;
            end
            default: ;
        endcase
        host_load(4'(code), hi, lo);
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial
    begin
        int   waited;
        int   density;
        int   sat_windows;
        logic seen_done;
        lfsr_state   = 32'h78b3543d;
        check_count  = 0;
        error_count  = 0;
        reset_global = 1'b1;
        i_run        = 1'b0;
        i_load       = 1'b0;
        i_sel        = neuro_pkg::SEL_WINDOW;
        i_data_hi    = '0;
        i_data_lo    = '0;
        i_spike_in   = 1'b0;
        repeat (RESET_CYCLES) tick();
        reset_global = 1'b0;

        // defaults, drive 0 keeps the neuron silent
        i_run  = 1'b1;
        waited = 0;
        do
        begin
            tick();
            waited++;
            compare(o_mn_spike, 1'b0, "o_mn_spike at default drive");
        end
        while (!o_cnt_done && (waited < DEFAULT_CYCLES));
        compare(waited, neuro_pkg::DEF_WINDOW_LEN, "cycles to first window end");
        compare(o_local_cnt, 16'd0, "first local count");
        compare(o_remote_cnt, 16'd0, "first remote count");

        // random loads, then a random run
        for (int r = 0; r < ROUNDS; r++)
        begin
            for (int n = 0; n < RANDOM_LOADS; n++)
                random_load();
            host_load(4'(4 + (random_bits(4) % 12)), 16'(random_bits(16)),
                      16'(random_bits(16)));
            // leak 0 in the first round
            host_load(4'(neuro_pkg::SEL_LEAK_SHIFT), 16'(random_bits(16)),
                      (r == 0) ? 16'd0 : 16'(random_bits(4)));
            density = int'(random_bits(3));
            for (int c = 0; c < ROUND_CYCLES; c++)
            begin
                i_run      = (random_bits(3) != 0);
                i_spike_in = (random_bits(3) < density);
                tick();
            end
        end

        // dense burst, fires every cycle, windows of 200
        i_run      = 1'b1;
        i_spike_in = 1'b1;
        host_load(4'(neuro_pkg::SEL_WINDOW), 16'd0, 16'd200);
        host_load(4'(neuro_pkg::SEL_THRESHOLD), 16'd0, 16'd4);
        host_load(4'(neuro_pkg::SEL_DRIVE), 16'd0, 16'd4);
        seen_done   = 1'b0;
        sat_windows = 0;
        for (int c = 0; c < SAT_CYCLES; c++)
        begin
            tick();
            if (o_cnt_done)
            begin
                // first end may close a window begun before the burst
                if (seen_done)
                begin
                    compare(o_local_cnt, SAT_LIMIT, "local count in burst");
                    compare(o_remote_cnt, SAT_LIMIT, "remote count in burst");
                    sat_windows++;
                end
                seen_done = 1'b1;
            end
        end
        if (sat_windows == 0)
        begin
            error_count++;
            $display("No full window ended during the dense burst at time %0t", $time);
        end

        $display("Checks %0d, mismatches %0d, assertion failures %0d",
                 check_count, error_count, UUT.chk.fail_count);
        if ((error_count == 0) && (UUT.chk.fail_count == 0))
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // run limit
    initial
    begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES)
        begin
            @(posedge ep50trig);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verilog.f
hw/neuro_pkg.sv
hw/param_bank.sv
hw/mn_neuron.sv
hw/spike_window_counter.sv
hw/emg_combiner.sv
hw/neuro_board_core.sv
verification/neuro_board_chk.sv
verification/tb_neuro_board.sv
